/* hw/decode_pkg.sv */
package decode_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;
    localparam int IMM_W = 20;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_MULDIV
    } unit_e;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_LU12I,
        ALU_SLTI,
        ALU_SLTUI,
        ALU_ADDI,
        ALU_ANDI,
        ALU_ORI,
        ALU_XORI,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_NOR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLLI,
        ALU_SRLI,
        ALU_SRAI
    } alu_op_e;

    typedef enum logic [2:0] {
        MD_NOP,
        MD_MUL,
        MD_MULH,
        MD_MULHU,
        MD_DIV,
        MD_MOD,
        MD_DIVU,
        MD_MODU
    } muldiv_op_e;

    // Major opcode fields
    localparam logic [6:0]  OPC_LU12I      = 7'b0001010;      // Bits 31..25
    localparam logic [6:0]  OPC_2RI12      = 7'b0000001;      // Bits 31..25
    localparam logic [11:0] OPC_3R         = 12'b000000000001; // Bits 31..20
    localparam logic [11:0] OPC_SHIFTI     = 12'b000000000100; // Bits 31..20
    localparam logic [2:0]  OPC_SHIFTI_SUB = 3'b001;          // Bits 17..15
    localparam logic [10:0] OPC_DIV        = 11'b00000000001;  // Bits 31..21
    localparam logic [3:0]  OPC_DIV_SUB    = 4'b0000;         // Bits 20..17

endpackage

/* hw/fetch_latch.sv */
`timescale 1ns/10ps

module fetch_latch import decode_pkg::*; #(
    parameter int DECODE_WIDTH = 2
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 bundle_valid,
    input  logic [XLEN-1:0]                      bundle_pc,
    input  logic [DECODE_WIDTH-1:0][XLEN-1:0]    bundle_instr,
    input  logic [DECODE_WIDTH-1:0]              slot_valid,
    input  logic                                 hold,
    input  logic                                 flush,
    output logic [DECODE_WIDTH-1:0][XLEN-1:0]    instr,
    output logic [DECODE_WIDTH-1:0][XLEN-1:0]    pc,
    output logic [DECODE_WIDTH-1:0]              instr_valid
);

    logic accept;

    assign accept = bundle_valid && !hold && !flush;

    // Slot payload only moves on an accepted bundle
    always_ff @(posedge clk) begin
        if (accept) begin
            instr <= bundle_instr;
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                pc[i] <= bundle_pc + XLEN'(4 * i); // Word-sized slots
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= '0;
        end else if (flush) begin
            instr_valid <= '0;
        end else if (!hold) begin
            instr_valid <= bundle_valid ? slot_valid : '0;
        end
    end

endmodule

/* hw/decode_lane.sv */
`timescale 1ns/10ps

module decode_lane import decode_pkg::*; #(
    parameter int LANE = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [XLEN-1:0]   instr,
    input  logic [XLEN-1:0]   pc,
    input  logic              instr_valid,
    input  logic              hold,
    input  logic              flush,
    output logic              dec_valid,
    output logic              illegal,
    output logic [XLEN-1:0]   pc_q,
    output unit_e             unit,
    output alu_op_e           alu_op,
    output muldiv_op_e        muldiv_op,
    output logic [IMM_W-1:0]  imm,
    output logic [REG_W-1:0]  rd,
    output logic              rd_en,
    output logic [REG_W-1:0]  rj,
    output logic              rj_en,
    output logic [REG_W-1:0]  rk,
    output logic              rk_en
);

    unit_e            unit_d;
    alu_op_e          alu_op_d;
    muldiv_op_e       muldiv_op_d;
    logic [IMM_W-1:0] imm_d;
    logic             rd_en_d;
    logic             rj_en_d;
    logic             rk_en_d;
    logic             legal;

    always_comb begin
        unit_d      = UNIT_NONE;
        alu_op_d    = ALU_NOP;
        muldiv_op_d = MD_NOP;
        imm_d       = '0;
        rd_en_d     = 1'b0;
        rj_en_d     = 1'b0;
        rk_en_d     = 1'b0;
        if (instr[31:25] == OPC_LU12I) begin
            unit_d   = UNIT_ALU;
            alu_op_d = ALU_LU12I;
            imm_d    = instr[24:5];                 // Upper 20-bit immediate
            rd_en_d  = 1'b1;
        end else if (instr[31:25] == OPC_2RI12) begin
            unit_d = UNIT_ALU;
            case (instr[24:22])
                3'b000:  alu_op_d = ALU_SLTI;
                3'b001:  alu_op_d = ALU_SLTUI;
                3'b010:  alu_op_d = ALU_ADDI;
                3'b101:  alu_op_d = ALU_ANDI;
                3'b110:  alu_op_d = ALU_ORI;
                3'b111:  alu_op_d = ALU_XORI;
                default: unit_d   = UNIT_NONE;       // Sub-op not kept
            endcase
            imm_d   = IMM_W'(instr[21:10]);
            rd_en_d = 1'b1;
            rj_en_d = 1'b1;
        end else if (instr[31:20] == OPC_SHIFTI && instr[17:15] == OPC_SHIFTI_SUB) begin
            unit_d = UNIT_ALU;
            case (instr[19:18])
                2'b00:   alu_op_d = ALU_SLLI;
                2'b01:   alu_op_d = ALU_SRLI;
                2'b10:   alu_op_d = ALU_SRAI;
                default: unit_d   = UNIT_NONE;
            endcase
            imm_d   = IMM_W'(instr[21:10]);
            rd_en_d = 1'b1;
            rj_en_d = 1'b1;
        end else if (instr[31:20] == OPC_3R) begin
            unit_d = UNIT_ALU;
            case (instr[19:15])
                5'b00000: alu_op_d = ALU_ADD;
                5'b00010: alu_op_d = ALU_SUB;
                5'b00100: alu_op_d = ALU_SLT;
                5'b00101: alu_op_d = ALU_SLTU;
                5'b01000: alu_op_d = ALU_NOR;
                5'b01001: alu_op_d = ALU_AND;
                5'b01010: alu_op_d = ALU_OR;
                5'b01011: alu_op_d = ALU_XOR;
                5'b01110: alu_op_d = ALU_SLL;
                5'b01111: alu_op_d = ALU_SRL;
                5'b10000: alu_op_d = ALU_SRA;
                5'b11000: begin
                    unit_d      = UNIT_MULDIV;
                    muldiv_op_d = MD_MUL;
                end
                5'b11001: begin
                    unit_d      = UNIT_MULDIV;
                    muldiv_op_d = MD_MULH;
                end
                5'b11010: begin
                    unit_d      = UNIT_MULDIV;
                    muldiv_op_d = MD_MULHU;
                end
                default:  unit_d = UNIT_NONE;
            endcase
            rd_en_d = 1'b1;
            rj_en_d = 1'b1;
            rk_en_d = 1'b1;
        end else if (instr[31:21] == OPC_DIV && instr[20:17] == OPC_DIV_SUB) begin
            unit_d = UNIT_MULDIV;
            case (instr[16:15])
                2'b00:   muldiv_op_d = MD_DIV;
                2'b01:   muldiv_op_d = MD_MOD;
                2'b10:   muldiv_op_d = MD_DIVU;
                default: muldiv_op_d = MD_MODU;
            endcase
            rd_en_d = 1'b1;
            rj_en_d = 1'b1;
            rk_en_d = 1'b1;
        end
        if (unit_d == UNIT_NONE) begin              // Unknown sub-op
            imm_d   = '0;
            rd_en_d = 1'b0;
            rj_en_d = 1'b0;
            rk_en_d = 1'b0;
        end
    end

    assign legal = (unit_d != UNIT_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
            unit      <= UNIT_NONE;
            alu_op    <= ALU_NOP;
            muldiv_op <= MD_NOP;
            imm       <= '0;
            rd        <= '0;
            rd_en     <= 1'b0;
            rj        <= '0;
            rj_en     <= 1'b0;
            rk        <= '0;
            rk_en     <= 1'b0;
        end else if (flush || (!hold && !instr_valid)) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
            unit      <= UNIT_NONE;
            alu_op    <= ALU_NOP;
            muldiv_op <= MD_NOP;
            imm       <= '0;
            rd        <= '0;
            rd_en     <= 1'b0;
            rj        <= '0;
            rj_en     <= 1'b0;
            rk        <= '0;
            rk_en     <= 1'b0;
        end else if (!hold) begin
            dec_valid <= legal;
            illegal   <= !legal;
            unit      <= unit_d;
            alu_op    <= alu_op_d;
            muldiv_op <= muldiv_op_d;
            imm       <= imm_d;
            rd        <= instr[4:0];
            rd_en     <= rd_en_d;
            rj        <= instr[9:5];
            rj_en     <= rj_en_d;
            rk        <= instr[14:10];
            rk_en     <= rk_en_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush && !hold && instr_valid) begin
            pc_q <= pc;
        end
    end

endmodule

/* hw/bundle_dispatch.sv */
`timescale 1ns/10ps

module bundle_dispatch import decode_pkg::*; #(
    parameter int DECODE_WIDTH = 2
) (
    input  logic [DECODE_WIDTH-1:0]             dec_valid,
    input  logic [DECODE_WIDTH-1:0]             illegal,
    input  logic [DECODE_WIDTH-1:0][XLEN-1:0]   pc,
    input  unit_e [DECODE_WIDTH-1:0]            unit,
    input  alu_op_e [DECODE_WIDTH-1:0]          alu_op,
    input  muldiv_op_e [DECODE_WIDTH-1:0]       muldiv_op,
    input  logic [DECODE_WIDTH-1:0][IMM_W-1:0]  imm,
    input  logic [DECODE_WIDTH-1:0][REG_W-1:0]  rd,
    input  logic [DECODE_WIDTH-1:0]             rd_en,
    input  logic [DECODE_WIDTH-1:0][REG_W-1:0]  rj,
    input  logic [DECODE_WIDTH-1:0]             rj_en,
    input  logic [DECODE_WIDTH-1:0][REG_W-1:0]  rk,
    input  logic [DECODE_WIDTH-1:0]             rk_en,
    output logic [DECODE_WIDTH-1:0]             out_valid,
    output unit_e [DECODE_WIDTH-1:0]            out_unit,
    output alu_op_e [DECODE_WIDTH-1:0]          out_alu_op,
    output muldiv_op_e [DECODE_WIDTH-1:0]       out_muldiv_op,
    output logic [DECODE_WIDTH-1:0][IMM_W-1:0]  out_imm,
    output logic [DECODE_WIDTH-1:0][REG_W-1:0]  out_rd,
    output logic [DECODE_WIDTH-1:0]             out_rd_en,
    output logic [DECODE_WIDTH-1:0][REG_W-1:0]  out_rj,
    output logic [DECODE_WIDTH-1:0]             out_rj_en,
    output logic [DECODE_WIDTH-1:0][REG_W-1:0]  out_rk,
    output logic [DECODE_WIDTH-1:0]             out_rk_en,
    output logic                                exc_valid,
    output logic [XLEN-1:0]                     exc_pc
);

    always_comb begin
        logic squash;
        logic keep;
        squash    = 1'b0;
        exc_valid = 1'b0;
        exc_pc    = '0;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            keep             = dec_valid[i] && !squash;
            out_valid[i]     = keep;
            out_unit[i]      = keep ? unit[i] : UNIT_NONE;
            out_alu_op[i]    = keep ? alu_op[i] : ALU_NOP;
            out_muldiv_op[i] = keep ? muldiv_op[i] : MD_NOP;
            out_imm[i]       = keep ? imm[i] : '0;
            out_rd[i]        = keep ? rd[i] : '0;
            out_rd_en[i]     = keep && rd_en[i];
            out_rj[i]        = keep ? rj[i] : '0;
            out_rj_en[i]     = keep && rj_en[i];
            out_rk[i]        = keep ? rk[i] : '0;
            out_rk_en[i]     = keep && rk_en[i];
            if (illegal[i] && !squash) begin    // Lowest illegal lane only
                exc_valid = 1'b1;
                exc_pc    = pc[i];
            end
            squash = squash || illegal[i];
        end
    end

endmodule

/* hw/decode_top.sv */
`timescale 1ns/10ps

module decode_top import decode_pkg::*; #(
    parameter int DECODE_WIDTH = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                bundle_valid,
    input  logic [XLEN-1:0]                     bundle_pc,
    input  logic [DECODE_WIDTH-1:0][XLEN-1:0]   bundle_instr,
    input  logic [DECODE_WIDTH-1:0]             slot_valid,
    input  logic                                hold,
    input  logic                                flush,
    output logic [DECODE_WIDTH-1:0]             out_valid,
    output unit_e [DECODE_WIDTH-1:0]            out_unit,
    output alu_op_e [DECODE_WIDTH-1:0]          out_alu_op,
    output muldiv_op_e [DECODE_WIDTH-1:0]       out_muldiv_op,
    output logic [DECODE_WIDTH-1:0][IMM_W-1:0]  out_imm,
    output logic [DECODE_WIDTH-1:0][REG_W-1:0]  out_rd,
    output logic [DECODE_WIDTH-1:0]             out_rd_en,
    output logic [DECODE_WIDTH-1:0][REG_W-1:0]  out_rj,
    output logic [DECODE_WIDTH-1:0]             out_rj_en,
    output logic [DECODE_WIDTH-1:0][REG_W-1:0]  out_rk,
    output logic [DECODE_WIDTH-1:0]             out_rk_en,
    output logic                                exc_valid,
    output logic [XLEN-1:0]                     exc_pc
);

    logic [DECODE_WIDTH-1:0][XLEN-1:0]   slot_instr;
    logic [DECODE_WIDTH-1:0][XLEN-1:0]   slot_pc;
    logic [DECODE_WIDTH-1:0]             slot_instr_valid;
    logic [DECODE_WIDTH-1:0]             lane_valid;
    logic [DECODE_WIDTH-1:0]             lane_illegal;
    logic [DECODE_WIDTH-1:0][XLEN-1:0]   lane_pc;
    unit_e [DECODE_WIDTH-1:0]            lane_unit;
    alu_op_e [DECODE_WIDTH-1:0]          lane_alu_op;
    muldiv_op_e [DECODE_WIDTH-1:0]       lane_muldiv_op;
    logic [DECODE_WIDTH-1:0][IMM_W-1:0]  lane_imm;
    logic [DECODE_WIDTH-1:0][REG_W-1:0]  lane_rd;
    logic [DECODE_WIDTH-1:0]             lane_rd_en;
    logic [DECODE_WIDTH-1:0][REG_W-1:0]  lane_rj;
    logic [DECODE_WIDTH-1:0]             lane_rj_en;
    logic [DECODE_WIDTH-1:0][REG_W-1:0]  lane_rk;
    logic [DECODE_WIDTH-1:0]             lane_rk_en;

    fetch_latch #(
        .DECODE_WIDTH(DECODE_WIDTH)
    ) u_fetch_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .bundle_valid(bundle_valid),
        .bundle_pc   (bundle_pc),
        .bundle_instr(bundle_instr),
        .slot_valid  (slot_valid),
        .hold        (hold),
        .flush       (flush),
        .instr       (slot_instr),
        .pc          (slot_pc),
        .instr_valid (slot_instr_valid)
    );

    for (genvar g = 0; g < DECODE_WIDTH; g++) begin : g_lane
        decode_lane #(
            .LANE(g)
        ) u_decode_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .instr      (slot_instr[g]),
            .pc         (slot_pc[g]),
            .instr_valid(slot_instr_valid[g]),
            .hold       (hold),
            .flush      (flush),
            .dec_valid  (lane_valid[g]),
            .illegal    (lane_illegal[g]),
            .pc_q       (lane_pc[g]),
            .unit       (lane_unit[g]),
            .alu_op     (lane_alu_op[g]),
            .muldiv_op  (lane_muldiv_op[g]),
            .imm        (lane_imm[g]),
            .rd         (lane_rd[g]),
            .rd_en      (lane_rd_en[g]),
            .rj         (lane_rj[g]),
            .rj_en      (lane_rj_en[g]),
            .rk         (lane_rk[g]),
            .rk_en      (lane_rk_en[g])
        );
    end

    bundle_dispatch #(
        .DECODE_WIDTH(DECODE_WIDTH)
    ) u_bundle_dispatch (
        .dec_valid    (lane_valid),
        .illegal      (lane_illegal),
        .pc           (lane_pc),
        .unit         (lane_unit),
        .alu_op       (lane_alu_op),
        .muldiv_op    (lane_muldiv_op),
        .imm          (lane_imm),
        .rd           (lane_rd),
        .rd_en        (lane_rd_en),
        .rj           (lane_rj),
        .rj_en        (lane_rj_en),
        .rk           (lane_rk),
        .rk_en        (lane_rk_en),
        .out_valid    (out_valid),
        .out_unit     (out_unit),
        .out_alu_op   (out_alu_op),
        .out_muldiv_op(out_muldiv_op),
        .out_imm      (out_imm),
        .out_rd       (out_rd),
        .out_rd_en    (out_rd_en),
        .out_rj       (out_rj),
        .out_rj_en    (out_rj_en),
        .out_rk       (out_rk),
        .out_rk_en    (out_rk_en),
        .exc_valid    (exc_valid),
        .exc_pc       (exc_pc)
    );

endmodule

/* verif/decode_asserts.sv */
`timescale 1ns/10ps

module decode_asserts import decode_pkg::*; #(
    parameter int DECODE_WIDTH = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [DECODE_WIDTH-1:0] out_valid,
    input  logic [DECODE_WIDTH-1:0] out_rd_en,
    input  logic [DECODE_WIDTH-1:0] out_rj_en,
    input  logic [DECODE_WIDTH-1:0] out_rk_en,
    input  logic                    exc_valid
);

    int exc_fail_count   = 0;
    int en_fail_count    = 0;
    int flush_fail_count = 0;

    // The illegal lane itself is never out_valid
    a_exc_gap: assert property (@(posedge clk) disable iff (!rst_n)
        exc_valid |-> !(&out_valid))
        else begin
            exc_fail_count++;
            $error("exc_valid raised while every lane is out_valid");
        end

    // Enables only on valid lanes and rd on every one
    a_en_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (out_rd_en | out_rj_en | out_rk_en) == out_valid)
        else begin
            en_fail_count++;
            $error("register enables do not match out_valid");
        end

    a_flush_clear: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (out_valid == '0 && !exc_valid))
        else begin
            flush_fail_count++;
            $error("outputs still valid in the cycle after flush");
        end

endmodule

bind decode_top decode_asserts #(
    .DECODE_WIDTH(DECODE_WIDTH)
) u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .out_valid(out_valid),
    .out_rd_en(out_rd_en),
    .out_rj_en(out_rj_en),
    .out_rk_en(out_rk_en),
    .exc_valid(exc_valid)
);

/* verif/tb_decode.sv */
`timescale 1ns/10ps

module tb_decode import decode_pkg::*;;

    localparam int DW     = 2;
    localparam int CYCLES = 3000;

    typedef struct packed {
        logic             valid;
        unit_e            unit;
        alu_op_e          alu;
        muldiv_op_e       md;
        logic [IMM_W-1:0] imm;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rj;
        logic [REG_W-1:0] rk;
        logic             rd_en;
        logic             rj_en;
        logic             rk_en;
    } lane_exp_t;

    // 3R function codes, including two unused ones
    localparam logic [15:0][4:0] FN_3R = {
        5'b00000, 5'b00010, 5'b00100, 5'b00101, 5'b01000, 5'b01001, 5'b01010, 5'b01011,
        5'b01110, 5'b01111, 5'b10000, 5'b11000, 5'b11001, 5'b11010, 5'b00001, 5'b11111
    };

    logic                               clk;
    logic                               rst_n;
    logic                               bundle_valid;
    logic [XLEN-1:0]                    bundle_pc;
    logic [DW-1:0][XLEN-1:0]            bundle_instr;
    logic [DW-1:0]                      slot_valid;
    logic                               hold;
    logic                               flush;
    logic [DW-1:0]                      out_valid;
    unit_e [DW-1:0]                     out_unit;
    alu_op_e [DW-1:0]                   out_alu_op;
    muldiv_op_e [DW-1:0]                out_muldiv_op;
    logic [DW-1:0][IMM_W-1:0]           out_imm;
    logic [DW-1:0][REG_W-1:0]           out_rd;
    logic [DW-1:0]                      out_rd_en;
    logic [DW-1:0][REG_W-1:0]           out_rj;
    logic [DW-1:0]                      out_rj_en;
    logic [DW-1:0][REG_W-1:0]           out_rk;
    logic [DW-1:0]                      out_rk_en;
    logic                               exc_valid;
    logic [XLEN-1:0]                    exc_pc;

    logic [31:0]                        lfsr;
    logic [DW-1:0]                      s1_valid;       // Latched slot stage
    logic [DW-1:0][XLEN-1:0]            s1_instr;
    logic [XLEN-1:0]                    s1_pc;
    lane_exp_t                          exp_lane [DW];  // Decoded stage
    logic                               exp_exc;
    logic [XLEN-1:0]                    exp_exc_pc;
    int                                 n_checks;
    int                                 n_errors;
    int                                 n_exc_seen;
    int                                 n_hold;
    int                                 n_flush;
    int                                 n_assert;

    decode_top #(
        .DECODE_WIDTH(DW)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .bundle_valid (bundle_valid),
        .bundle_pc    (bundle_pc),
        .bundle_instr (bundle_instr),
        .slot_valid   (slot_valid),
        .hold         (hold),
        .flush        (flush),
        .out_valid    (out_valid),
        .out_unit     (out_unit),
        .out_alu_op   (out_alu_op),
        .out_muldiv_op(out_muldiv_op),
        .out_imm      (out_imm),
        .out_rd       (out_rd),
        .out_rd_en    (out_rd_en),
        .out_rj       (out_rj),
        .out_rj_en    (out_rj_en),
        .out_rk       (out_rk),
        .out_rk_en    (out_rk_en),
        .exc_valid    (exc_valid),
        .exc_pc       (exc_pc)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [2:0] cls;
        cls = 3'(rand_bits(3));
        case (cls)
            3'd0:    return {7'b0001010, 25'(rand_bits(25))};
            3'd1:    return {7'b0000001, 25'(rand_bits(25))};
            3'd2:    return {12'b000000000100, 2'(rand_bits(2)), 3'b001, 15'(rand_bits(15))};
            3'd3,
            3'd4:    return {12'b000000000001, FN_3R[4'(rand_bits(4))], 15'(rand_bits(15))};
            3'd5:    return {11'b00000000001, 4'b0000, 17'(rand_bits(17))};
            3'd6:    return {7'b1111111, 25'(rand_bits(25))};
            default: return rand_bits(32);
        endcase
    endfunction

    // Expected decode of one valid slot; valid means legal
    function automatic lane_exp_t decode_ref(input logic [31:0] ins);
        lane_exp_t e;
        logic      uses_rk;
        e       = '0;
        uses_rk = 1'b0;
        if (ins[31:25] == 7'b0001010) begin
            e.alu = ALU_LU12I;
            e.imm = ins[24:5];
        end else if (ins[31:25] == 7'b0000001) begin
            case (ins[24:22])
                3'b000:  e.alu = ALU_SLTI;
                3'b001:  e.alu = ALU_SLTUI;
                3'b010:  e.alu = ALU_ADDI;
                3'b101:  e.alu = ALU_ANDI;
                3'b110:  e.alu = ALU_ORI;
                3'b111:  e.alu = ALU_XORI;
                default: e.alu = ALU_NOP;
            endcase
            e.imm = {8'b0, ins[21:10]};
        end else if (ins[31:20] == 12'b000000000100 && ins[17:15] == 3'b001) begin
            case (ins[19:18])
                2'b00:   e.alu = ALU_SLLI;
                2'b01:   e.alu = ALU_SRLI;
                2'b10:   e.alu = ALU_SRAI;
                default: e.alu = ALU_NOP;
            endcase
            e.imm = {8'b0, ins[21:10]};
        end else if (ins[31:20] == 12'b000000000001) begin
            uses_rk = 1'b1;
            case (ins[19:15])
                5'b00000: e.alu = ALU_ADD;
                5'b00010: e.alu = ALU_SUB;
                5'b00100: e.alu = ALU_SLT;
                5'b00101: e.alu = ALU_SLTU;
                5'b01000: e.alu = ALU_NOR;
                5'b01001: e.alu = ALU_AND;
                5'b01010: e.alu = ALU_OR;
                5'b01011: e.alu = ALU_XOR;
                5'b01110: e.alu = ALU_SLL;
                5'b01111: e.alu = ALU_SRL;
                5'b10000: e.alu = ALU_SRA;
                5'b11000: e.md  = MD_MUL;
                5'b11001: e.md  = MD_MULH;
                5'b11010: e.md  = MD_MULHU;
                default:  e.alu = ALU_NOP;
            endcase
        end else if (ins[31:21] == 11'b00000000001 && ins[20:17] == 4'b0000) begin
            uses_rk = 1'b1;
            case (ins[16:15])
                2'b00:   e.md = MD_DIV;
                2'b01:   e.md = MD_MOD;
                2'b10:   e.md = MD_DIVU;
                default: e.md = MD_MODU;
            endcase
        end
        if (e.alu != ALU_NOP) begin
            e.unit = UNIT_ALU;
        end else if (e.md != MD_NOP) begin
            e.unit = UNIT_MULDIV;
        end
        if (e.unit == UNIT_NONE) begin
            return '0;
        end
        e.valid = 1'b1;
        e.rd    = ins[4:0];
        e.rj    = ins[9:5];
        e.rk    = ins[14:10];
        e.rd_en = 1'b1;
        e.rj_en = (e.alu != ALU_LU12I);
        e.rk_en = uses_rk;
        return e;
    endfunction

    // Model reaction to the inputs sampled at this rising edge
    task automatic update_model();
        lane_exp_t e;
        logic      squash;
        logic      bad;
        if (hold) n_hold++;
        if (flush) n_flush++;
        if (flush) begin
            s1_valid = '0;
            exp_exc  = 1'b0;
            exp_exc_pc = '0;
            for (int i = 0; i < DW; i++) exp_lane[i] = '0;
        end else if (!hold) begin
            squash     = 1'b0;
            exp_exc    = 1'b0;
            exp_exc_pc = '0;
            for (int i = 0; i < DW; i++) begin
                e   = decode_ref(s1_instr[i]);
                bad = s1_valid[i] && !e.valid;
                if (bad && !squash) begin
                    exp_exc    = 1'b1;
                    exp_exc_pc = s1_pc + XLEN'(4 * i);
                end
                exp_lane[i] = (s1_valid[i] && !squash) ? e : '0;
                squash      = squash || bad;
            end
            s1_valid = bundle_valid ? slot_valid : '0;
            if (bundle_valid) begin
                s1_instr = bundle_instr;
                s1_pc    = bundle_pc;
            end
        end
    endtask

    task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_errors++;
        $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic check_unit(input string name, input unit_e got, input unit_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_alu(input string name, input alu_op_e got, input alu_op_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_md(input string name, input muldiv_op_e got, input muldiv_op_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_imm(input string name, input logic [IMM_W-1:0] got,
                             input logic [IMM_W-1:0] exp);
        n_checks++;
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_reg(input string name, input logic [REG_W-1:0] got,
                             input logic [REG_W-1:0] exp);
        n_checks++;
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        n_checks++;
        if (got !== exp) report_value(name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < DW; i++) begin
            check_bit($sformatf("out_valid[%0d]", i), out_valid[i], exp_lane[i].valid);
            check_unit($sformatf("out_unit[%0d]", i), out_unit[i], exp_lane[i].unit);
            check_alu($sformatf("out_alu_op[%0d]", i), out_alu_op[i], exp_lane[i].alu);
            check_md($sformatf("out_muldiv_op[%0d]", i), out_muldiv_op[i], exp_lane[i].md);
            check_imm($sformatf("out_imm[%0d]", i), out_imm[i], exp_lane[i].imm);
            check_reg($sformatf("out_rd[%0d]", i), out_rd[i], exp_lane[i].rd);
            check_reg($sformatf("out_rj[%0d]", i), out_rj[i], exp_lane[i].rj);
            check_reg($sformatf("out_rk[%0d]", i), out_rk[i], exp_lane[i].rk);
            check_bit($sformatf("out_rd_en[%0d]", i), out_rd_en[i], exp_lane[i].rd_en);
            check_bit($sformatf("out_rj_en[%0d]", i), out_rj_en[i], exp_lane[i].rj_en);
            check_bit($sformatf("out_rk_en[%0d]", i), out_rk_en[i], exp_lane[i].rk_en);
        end
        check_bit("exc_valid", exc_valid, exp_exc);
        check_pc("exc_pc", exc_pc, exp_exc_pc);
        if (exc_valid) n_exc_seen++;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        update_model();
        #1;
        compare_outputs();
    endtask

    // A bundle stalled by hold stays on the inputs until taken
    task automatic drive_inputs();
        if (!(hold && bundle_valid)) begin
            bundle_valid = (rand_bits(2) != 0);
            bundle_pc    = rand_bits(32) & 32'hFFFF_FFFC;
            for (int i = 0; i < DW; i++) bundle_instr[i] = gen_instr();
            slot_valid = DW'(rand_bits(DW));
        end
        hold  = (rand_bits(3) == 0);
        flush = (rand_bits(4) == 0);
    endtask

    task automatic drain_pipeline();
        int waited;
        bundle_valid = 1'b0;
        hold         = 1'b0;
        flush        = 1'b0;
        waited       = 0;
        do begin
            step_cycle();
            waited++;
        end while ((out_valid != '0 || exc_valid || s1_valid != '0) && waited < 10);
        if (out_valid != '0 || exc_valid || s1_valid != '0) begin
            n_errors++;
            $display("timeout: pipeline did not empty within 10 cycles of idle input");
        end
    endtask

    initial begin
        #(100 * (CYCLES + 100));
        $display("timeout: simulation ran past its cycle limit");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        bundle_valid = 1'b0;
        bundle_pc    = '0;
        bundle_instr = '0;
        slot_valid   = '0;
        hold         = 1'b0;
        flush        = 1'b0;
        lfsr         = 32'd68973;
        s1_valid     = '0;
        s1_instr     = '0;
        s1_pc        = '0;
        exp_exc      = 1'b0;
        exp_exc_pc   = '0;
        for (int i = 0; i < DW; i++) exp_lane[i] = '0;
        n_checks   = 0;
        n_errors   = 0;
        n_exc_seen = 0;
        n_hold     = 0;
        n_flush    = 0;
        repeat (8) @(posedge clk);
        #1;
        compare_outputs();                              // Reset values
        rst_n = 1'b1;
        repeat (CYCLES) begin
            step_cycle();
            drive_inputs();
        end
        drain_pipeline();
        if (n_exc_seen == 0 || n_hold == 0 || n_flush == 0) begin
            n_errors++;
            $display("stimulus never produced an exception, a hold or a flush");
        end
        n_assert = dut.u_asserts.exc_fail_count + dut.u_asserts.en_fail_count
                 + dut.u_asserts.flush_fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d, exceptions %0d, holds %0d, flushes %0d",
                 n_checks, n_errors, n_assert, n_exc_seen, n_hold, n_flush);
        if (n_errors == 0 && n_assert == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/decode_pkg.sv
hw/fetch_latch.sv
hw/decode_lane.sv
hw/bundle_dispatch.sv
hw/decode_top.sv
verif/decode_asserts.sv
verif/tb_decode.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_decode -o sim_decode \
    && ./obj_dir/sim_decode +verilator+error+limit+1000 \
        | tee /dev/stderr | grep "TESTS PASSED" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
